// File: program.hex
// one 16-bit instruction word per line, loaded from address 0
// word nibbles are opcode, dst (condition for branches), ext, src; imm8 is ext and src
F104 // 00 lui  r1, 0x04
9101 // 01 subi r1, 1         r1 = switch word 0x3ff
F204 // 02 lui  r2, 0x04
9202 // 03 subi r2, 2         r2 = led word 0x3fe
FD02 // 04 lui  r13, 0x02     scratch word 0x200
DE25 // 05 movi r14, 0x25     subroutine address
4301 // 06 load r3, [r1]      loop top, s = switches
04D3 // 07 mov  r4, r3
5409 // 08 addi r4, 9
9406 // 09 subi r4, 6
D502 // 0a movi r5, 2
0455 // 0b add  r4, r5        s + 5
4442 // 0c stor r4, [r2]      write 1
F601 // 0d lui  r6, 0x01
2655 // 0e ori  r6, 0x55      0x155
04D3 // 0f mov  r4, r3
0436 // 10 xor  r4, r6
8403 // 11 lsh  r4, 3
8412 // 12 rsh  r4, 2         net shift left by one
4442 // 13 stor r4, [r2]      write 2
07D3 // 14 mov  r7, r3
170F // 15 andi r7, 0x0f      count
D800 // 16 movi r8, 0         sum
D900 // 17 movi r9, 0
B700 // 18 cmpi r7, 0
C005 // 19 beq  +5            zero count skips the loop
0857 // 1a add  r8, r7
9701 // 1b subi r7, 1
07B9 // 1c cmp  r7, r9
C1FD // 1d bne  -3
4842 // 1e stor r8, [r2]      write 3
0AD3 // 1f mov  r10, r3
3AFF // 20 xori r10, 0xff     inverse of s
4A4D // 21 stor r10, [r13]
7F0E // 22 jal  r15, r14
4B42 // 23 stor r11, [r2]     write 4
CEE2 // 24 buc  -30           back to loop top
4B0D // 25 load r11, [r13]    subroutine
6E0F // 26 juc  r15

// File: tb.f
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/alu.sv
hdl/registerFile.sv
hdl/programStatusReg.sv
hdl/bram.sv
hdl/controller.sv
hdl/datapath.sv
hdl/cpuTop.sv
verification/clockGen.sv
verification/cpuTb.sv

// File: Bender.yml
package:
  name: cpu16

sources:
  - hdl/isaPkg.sv
  - hdl/ctrlPkg.sv
  - hdl/alu.sv
  - hdl/registerFile.sv
  - hdl/programStatusReg.sv
  - hdl/bram.sv
  - hdl/controller.sv
  - hdl/datapath.sv
  - hdl/cpuTop.sv
  - target: test
    files:
      - verification/clockGen.sv
      - verification/cpuTb.sv

// File: verification/cpuTb.sv
/*
 * cpu testbench
 * runs the led program with xorshift switch values and checks every
 * led write and the reset state with assertions
 */
`timescale 1ns/1ps
`default_nettype none

module cpuTb
	import isaPkg::*;
();

	localparam int passTotal      = 40;
	localparam int instrPerPass   = 200;  // upper bound on a pass of about 100
	localparam int cyclesPerInstr = 4;    // worst case for loads
	localparam int clkPeriodNs    = 8;
	localparam int timeoutNs      = passTotal * instrPerPass * cyclesPerInstr * clkPeriodNs;
	localparam int driveDelayNs   = 1;
	localparam logic [31:0] seed  = 32'd31;

	logic               clk;
	logic               arstN;
	logic [ioWidth-1:0] switches;
	logic [ioWidth-1:0] leds;
	logic               ledStrobe;
	flagsT              flags;

	logic [31:0]        rngState;
	logic [ioWidth-1:0] expLeds;
	int strobeIdx = 0;          // 1..4 inside a pass
	int passCount = 0;

	clockGen u_clockGen (
		.clk   (clk),
		.arstN (arstN)
	);

	cpuTop u_cpuTop (
		.clk       (clk),
		.arstN     (arstN),
		.switches  (switches),
		.leds      (leds),
		.ledStrobe (ledStrobe),
		.flags     (flags)
	);

	// 32 bit xorshift whose low bits drive the switches
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// led value of write idx for switch value s
	function automatic logic [ioWidth-1:0] expectedLeds(input int idx, input logic [ioWidth-1:0] s);
		int n;
		int acc;
		int value;
		n   = s & 'hF;
		acc = 0;
		for (int k = 1; k <= n; k++) begin
			acc = acc + k;  // zero count gives 0
		end
		case (idx)
			1:       value = s + 5;
			2:       value = (s ^ 'h155) << 1;
			3:       value = acc;
			default: value = ~s;
		endcase
		return value[ioWidth-1:0];  // leds keep 10 bits
	endfunction

	function automatic string checkName(input int idx);
		case (idx)
			1:       return "arithImm";
			2:       return "logicShiftLui";
			3:       return "branchLoop";
			default: return "memLink";
		endcase
	endfunction

	task automatic reportMismatch(input string testName, input int expected, input int actual);
		$display("FAIL %s expected 0x%0h actual 0x%0h", testName, expected, actual);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	// outputs that reset clears
	task automatic verifyResetState();
		assert (leds == '0) else reportMismatch("reset leds", 0, leds);
		assert (ledStrobe == 1'b0) else reportMismatch("reset ledStrobe", 0, ledStrobe);
		assert (flags == '0) else reportMismatch("reset flags", 0, flags);
	endtask

	// reset state on every falling edge in reset and through the first cycle after it
	initial begin
		@(posedge clk);  // first real clock edge
		while (!arstN) begin
			@(negedge clk);
			verifyResetState();
		end
		@(negedge clk);  // first full cycle out of reset
		verifyResetState();
	end

	// led writes checked on the falling edge
	always @(negedge clk) begin
		if (arstN && ledStrobe) begin
			strobeIdx = (strobeIdx % 4) + 1;
			expLeds   = expectedLeds(strobeIdx, switches);
			assert (leds == expLeds) else reportMismatch(checkName(strobeIdx), expLeds, leds);
			if (strobeIdx == 4) passCount++;  // pass done
		end
	end

	// new switch value only after the fourth write of a pass
	initial begin
		rngState = xorshift(seed);
		switches = rngState[ioWidth-1:0];
		@(posedge arstN);
		for (int p = 1; p <= passTotal; p++) begin
			wait (passCount == p);
			if (p < passTotal) begin
				@(posedge clk);
				#(driveDelayNs);
				rngState = xorshift(rngState);
				switches = rngState[ioWidth-1:0];
			end
		end
		$display("Simulation passed");
		$finish;
	end

	// watchdog
	initial begin
		#(timeoutNs);
		$display("watchdog expired after %0d ns, the program stopped writing the leds",
			timeoutNs);
		$display("Simulation failed");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

// File: verification/clockGen.sv
/*
 * testbench clock and reset
 * 8 ns clock, active low reset held for the first 5 rising edges
 */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic arstN
);

	localparam int halfPeriodNs = 4;  // 8 ns period
	localparam int resetCycles  = 5;

	initial begin
		clk = 1'b0;
		forever #(halfPeriodNs) clk = ~clk;
	end

	initial begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#1 arstN = 1'b1; // release just after the edge
	end

endmodule

`default_nettype wire

// File: hdl/cpuTop.sv
/*
 * cpu top
 * controller, status register, datapath and block ram
 */
`timescale 1ns/1ps
`default_nettype none

module cpuTop
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  logic               clk,
	input  logic               arstN,
	input  logic [ioWidth-1:0] switches,
	output logic [ioWidth-1:0] leds,
	output logic               ledStrobe,
	output flagsT              flags
);

	ctrlT  ctrl;
	instrT instr;
	flagsT aluFlags;
	logic  condPass;
	logic [wordWidth-1:0] memAddrA;
	logic [wordWidth-1:0] memAddrB;
	logic [wordWidth-1:0] memWriteData;
	logic [wordWidth-1:0] memDataA;
	logic [wordWidth-1:0] memDataB;

	controller u_controller (
		.clk      (clk),
		.arstN    (arstN),
		.instr    (instr),
		.condPass (condPass),
		.ctrl     (ctrl),
		.state    ()
	);

	programStatusReg u_psr (
		.clk      (clk),
		.arstN    (arstN),
		.en       (ctrl.psrEn),
		.flagsIn  (aluFlags),
		.cond     (condT'(instr.dst)),  // condition sits in the dst field
		.condPass (condPass),
		.flags    (flags)
	);

	datapath u_datapath (
		.clk          (clk),
		.arstN        (arstN),
		.ctrl         (ctrl),
		.memDataA     (memDataA),
		.memDataB     (memDataB),
		.memAddrA     (memAddrA),
		.memAddrB     (memAddrB),
		.memWriteData (memWriteData),
		.instr        (instr),
		.aluFlags     (aluFlags)
	);

	bram u_bram (
		.clk       (clk),
		.arstN     (arstN),
		.weB       (ctrl.memWrEn),
		.addrA     (memAddrA),
		.addrB     (memAddrB),
		.dataB     (memWriteData),
		.switches  (switches),
		.qA        (memDataA),
		.qB        (memDataB),
		.leds      (leds),
		.ledStrobe (ledStrobe)
	);

endmodule

`default_nettype wire

// File: hdl/datapath.sv
/*
 * datapath
 * pc, instruction register, alu/register file and the operand,
 * pc and write back muxes
 */
`timescale 1ns/1ps
`default_nettype none

module datapath
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  logic                 clk,
	input  logic                 arstN,
	input  ctrlT                 ctrl,
	input  logic [wordWidth-1:0] memDataA,    // instruction word
	input  logic [wordWidth-1:0] memDataB,    // load data
	output logic [wordWidth-1:0] memAddrA,
	output logic [wordWidth-1:0] memAddrB,
	output logic [wordWidth-1:0] memWriteData,
	output instrT                instr,
	output flagsT                aluFlags
);

	logic [wordWidth-1:0] pc;
	logic [wordWidth-1:0] pcPlus;      // also the jal link
	logic [wordWidth-1:0] pcIn;
	logic [wordWidth-1:0] signImm;
	logic [wordWidth-1:0] luiVal;
	logic [wordWidth-1:0] aluIn1;
	logic [wordWidth-1:0] aluIn2;
	logic [wordWidth-1:0] aluResult;
	logic [wordWidth-1:0] rfWriteData;
	logic [wordWidth-1:0] readData1;   // dst register
	logic [wordWidth-1:0] readData2;   // src register

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc    <= '0;
			instr <= '0;
		end else begin
			if (ctrl.pcEn) pc <= pcIn;
			if (ctrl.instrEn) instr <= instrT'(memDataA);
		end
	end

	assign pcPlus  = pc + 1'b1;
	assign signImm = {{8{instr.ext[3]}}, instr.ext, instr.src}; // imm8 sign extended
	assign luiVal  = {instr.ext, instr.src, 8'h00};

	assign aluIn1 = ctrl.a1Pc ? pc : readData1;

	always_comb begin
		case (ctrl.a2Sel)
			a2Shamt:   aluIn2 = {{(wordWidth-4){1'b0}}, instr.src};
			a2SignImm: aluIn2 = signImm;
			default:   aluIn2 = readData2;
		endcase
	end

	always_comb begin
		case (ctrl.pcSel)
			pcReg:   pcIn = readData2;
			pcAlu:   pcIn = aluResult;   // branch target
			default: pcIn = pcPlus;
		endcase
	end

	always_comb begin
		case (ctrl.rwSel)
			rwMem:   rfWriteData = memDataB;
			rwLink:  rfWriteData = pcPlus;
			rwLui:   rfWriteData = luiVal;
			default: rfWriteData = aluResult;
		endcase
	end

	assign memAddrA     = pc;
	assign memAddrB     = readData2;  // address in src
	assign memWriteData = readData1;  // store data from dst

	registerFile u_registerFile (
		.clk       (clk),
		.arstN     (arstN),
		.writeEn   (ctrl.rfEn),
		.dstAddr   (instr.dst),
		.srcAddr   (instr.src),
		.writeData (rfWriteData),
		.readData1 (readData1),
		.readData2 (readData2)
	);

	alu u_alu (
		.aluOp  (ctrl.aluOp),
		.in1    (aluIn1),
		.in2    (aluIn2),
		.result (aluResult),
		.flags  (aluFlags)
	);

endmodule

`default_nettype wire

// File: hdl/controller.sv
/*
 * controller
 * fetch / decode / execute / memRead fsm, decodes opcode and ext into ctrl
 */
`timescale 1ns/1ps
`default_nettype none

module controller
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  logic  clk,
	input  logic  arstN,
	input  instrT instr,
	input  logic  condPass,  // from status register
	output ctrlT  ctrl,
	output stateT state
);

	stateT stateNext;
	logic  isLoad;
	aluOpT regAluOp;   // alu op for regOp
	logic  regWrites;  // regOp writes dst
	logic  regFlags;   // regOp latches flags

	assign isLoad = (instr.opcode == memOp) && (instr.ext == extLoad);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) state <= fetch;
		else state <= stateNext;
	end

	always_comb begin
		case (state)
			fetch:   stateNext = decode;
			decode:  stateNext = execute;
			execute: stateNext = isLoad ? memRead : fetch;
			memRead: stateNext = fetch;
			default: stateNext = fetch; // memWrite unused, stores finish in execute
		endcase
	end

	// register ops, decoded from ext
	always_comb begin
		regWrites = 1'b1;
		regFlags  = 1'b0;
		case (instr.ext)
			extAdd: begin
				regAluOp = aluAdd;
				regFlags = 1'b1;
			end
			extSub: begin
				regAluOp = aluSub;
				regFlags = 1'b1;
			end
			extCmp: begin
				regAluOp  = aluSub; // flags only
				regFlags  = 1'b1;
				regWrites = 1'b0;
			end
			extAnd:  regAluOp = aluAnd;
			extOr:   regAluOp = aluOr;
			extXor:  regAluOp = aluXor;
			extMov:  regAluOp = aluMov;
			default: begin
				regAluOp  = aluPass2; // unknown ext is a nop
				regWrites = 1'b0;
			end
		endcase
	end

	always_comb begin
		ctrl       = '0;
		ctrl.pcSel = pcNext;
		ctrl.a2Sel = a2Reg;
		ctrl.rwSel = rwAlu;
		ctrl.aluOp = aluPass2;

		case (state)
			decode: ctrl.instrEn = 1'b1; // ir from port a
			execute: begin
				ctrl.pcEn = 1'b1; // every instruction moves the pc here
				case (instr.opcode)
					regOp: begin
						ctrl.aluOp = regAluOp;
						ctrl.rfEn  = regWrites;
						ctrl.psrEn = regFlags;
					end
					addi, subi, andi, ori, xori: begin
						ctrl.a2Sel = a2SignImm;
						ctrl.rfEn  = 1'b1;
						ctrl.psrEn = (instr.opcode == addi) || (instr.opcode == subi);
						case (instr.opcode)
							addi:    ctrl.aluOp = aluAdd;
							subi:    ctrl.aluOp = aluSub;
							andi:    ctrl.aluOp = aluAnd;
							ori:     ctrl.aluOp = aluOr;
							default: ctrl.aluOp = aluXor;
						endcase
					end
					cmpi: begin
						ctrl.a2Sel = a2SignImm;
						ctrl.aluOp = aluSub;
						ctrl.psrEn = 1'b1;
					end
					movi: begin
						ctrl.a2Sel = a2SignImm;
						ctrl.aluOp = aluMov;
						ctrl.rfEn  = 1'b1;
					end
					lui: begin
						ctrl.rwSel = rwLui; // imm8 into the upper byte
						ctrl.rfEn  = 1'b1;
					end
					shift: begin
						ctrl.a2Sel = a2Shamt;
						ctrl.aluOp = (instr.ext == extShiftRight) ? aluRsh : aluLsh;
						ctrl.rfEn  = 1'b1;
					end
					memOp: ctrl.memWrEn = (instr.ext == extStor); // load waits for memRead
					bcond: begin
						ctrl.a1Pc  = 1'b1; // pc + disp
						ctrl.a2Sel = a2SignImm;
						ctrl.aluOp = aluAdd;
						if (condPass) ctrl.pcSel = pcAlu;
					end
					jcond: if (condPass) ctrl.pcSel = pcReg;
					jal: begin
						ctrl.pcSel = pcReg;
						ctrl.rwSel = rwLink; // return address into dst
						ctrl.rfEn  = 1'b1;
					end
					default: ; // unused opcodes just step the pc
				endcase
			end
			memRead: begin
				ctrl.rwSel = rwMem; // port b data
				ctrl.rfEn  = 1'b1;
			end
			default: ; // fetch, all enables low
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/bram.sv
/*
 * block ram
 * dual port sync ram preloaded with the program, port b also maps
 * the switches (read) and the led register (write)
 */
`timescale 1ns/1ps
`default_nettype none

module bram
	import isaPkg::*;
(
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 weB,
	input  logic [wordWidth-1:0] addrA,
	input  logic [wordWidth-1:0] addrB,
	input  logic [wordWidth-1:0] dataB,
	input  logic [ioWidth-1:0]   switches,
	output logic [wordWidth-1:0] qA,
	output logic [wordWidth-1:0] qB,
	output logic [ioWidth-1:0]   leds,
	output logic                 ledStrobe
);

	logic [wordWidth-1:0] mem [memDepth];
	logic ledHit;     // port b hits the led word
	logic switchHit;  // port b hits the switch word

	initial begin
		$readmemh("program.hex", mem);
	end

	assign ledHit    = (addrB == ledAddr);
	assign switchHit = (addrB == switchAddr);

	// port a, instruction fetch
	always_ff @(posedge clk) begin
		qA <= mem[addrA[memAddrWidth-1:0]];
	end

	// port b, loads and stores
	always_ff @(posedge clk) begin
		if (weB && !ledHit) mem[addrB[memAddrWidth-1:0]] <= dataB;
		if (switchHit) qB <= {{(wordWidth-ioWidth){1'b0}}, switches};
		else qB <= mem[addrB[memAddrWidth-1:0]]; // read old data on collision
	end

	// led register, strobe high the cycle after the store
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			leds      <= '0;
			ledStrobe <= 1'b0;
		end else begin
			ledStrobe <= weB && ledHit;
			if (weB && ledHit) leds <= dataB[ioWidth-1:0];
		end
	end

endmodule

`default_nettype wire

// File: hdl/programStatusReg.sv
/*
 * program status register
 * keeps the last latched flags and resolves branch conditions against them
 */
`timescale 1ns/1ps
`default_nettype none

module programStatusReg
	import isaPkg::*;
(
	input  logic  clk,
	input  logic  arstN,
	input  logic  en,       // arithmetic and cmp only
	input  flagsT flagsIn,
	input  condT  cond,
	output logic  condPass,
	output flagsT flags
);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) flags <= '0;
		else if (en) flags <= flagsIn;
	end

	always_comb begin
		case (cond)
			eq:      condPass = flags.zero;
			ne:      condPass = !flags.zero;
			cs:      condPass = flags.carry;
			cc:      condPass = !flags.carry;
			hi:      condPass = !flags.lower && !flags.zero;    // unsigned greater
			ls:      condPass = flags.lower || flags.zero;
			gt:      condPass = !flags.negative && !flags.zero; // signed greater
			le:      condPass = flags.negative || flags.zero;
			uc:      condPass = 1'b1;
			default: condPass = 1'b0; // unused codes never taken
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/registerFile.sv
/*
 * register file
 * 16 x 16, two combinational reads (dst, src), one write to dst
 */
`timescale 1ns/1ps
`default_nettype none

module registerFile
	import isaPkg::*;
(
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 writeEn,
	input  logic [3:0]           dstAddr,
	input  logic [3:0]           srcAddr,
	input  logic [wordWidth-1:0] writeData,
	output logic [wordWidth-1:0] readData1,
	output logic [wordWidth-1:0] readData2
);

	logic [wordWidth-1:0] regs [regCount];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[dstAddr] <= writeData; // results always land in dst
		end
	end

	assign readData1 = regs[dstAddr]; // alu in1, store data
	assign readData2 = regs[srcAddr]; // alu in2, load/store address, jump target

endmodule

`default_nettype wire

// File: hdl/alu.sv
/*
 * alu
 * result plus carry/overflow from add and sub, compare flags from in1 vs in2
 */
`timescale 1ns/1ps
`default_nettype none

module alu
	import isaPkg::*;
(
	input  aluOpT                aluOp,
	input  logic [wordWidth-1:0] in1,
	input  logic [wordWidth-1:0] in2,
	output logic [wordWidth-1:0] result,
	output flagsT                flags
);

	logic [wordWidth:0] sum;  // msb is carry out
	logic [wordWidth:0] diff; // msb is borrow

	assign sum  = {1'b0, in1} + {1'b0, in2};
	assign diff = {1'b0, in1} - {1'b0, in2};

	always_comb begin
		result         = '0;
		flags.carry    = 1'b0;
		flags.overflow = 1'b0;

		case (aluOp)
			aluAdd: begin
				result         = sum[wordWidth-1:0];
				flags.carry    = sum[wordWidth];
				// same sign in, other sign out
				flags.overflow = (in1[wordWidth-1] == in2[wordWidth-1]) &&
					(sum[wordWidth-1] != in1[wordWidth-1]);
			end
			aluSub: begin
				result         = diff[wordWidth-1:0];
				flags.carry    = diff[wordWidth];   // borrow
				flags.overflow = (in1[wordWidth-1] != in2[wordWidth-1]) &&
					(diff[wordWidth-1] != in1[wordWidth-1]);
			end
			aluAnd:           result = in1 & in2;
			aluOr:            result = in1 | in2;
			aluXor:           result = in1 ^ in2;
			aluLsh:           result = in1 << in2[3:0]; // 4 bit amount
			aluRsh:           result = in1 >> in2[3:0]; // logical
			aluMov, aluPass2: result = in2;             // pass2 is the idle op
			default:          result = '0;
		endcase

		// group two is a plain compare, so cmp is sub with no write back
		flags.zero     = (in1 == in2);
		flags.lower    = (in1 < in2);                   // unsigned
		flags.negative = ($signed(in1) < $signed(in2)); // signed
	end

endmodule

`default_nettype wire

// File: hdl/ctrlPkg.sv
/*
 * control package
 * controller states, datapath mux selects and the control word
 */
`default_nettype none

package ctrlPkg;

	import isaPkg::*;

	typedef enum logic [2:0] {
		fetch, decode, execute, memRead, memWrite
	} stateT;

	typedef enum logic [1:0] {
		pcNext, // pc + 1
		pcReg,  // src register, jumps
		pcAlu   // pc + disp, branches
	} pcSelT;

	typedef enum logic [1:0] {
		a2Reg,     // src register
		a2Shamt,   // zero extended src field
		a2SignImm  // sign extended imm8
	} a2SelT;

	typedef enum logic [1:0] {
		rwMem, rwLink, rwAlu, rwLui
	} rwSelT;

	typedef struct packed {
		logic  pcEn;
		logic  instrEn;
		logic  rfEn;
		logic  psrEn;
		logic  memWrEn;  // port b
		logic  a1Pc;     // alu in1 from pc
		pcSelT pcSel;
		a2SelT a2Sel;
		rwSelT rwSel;
		aluOpT aluOp;
	} ctrlT;

endpackage

`default_nettype wire

// File: hdl/isaPkg.sv
/*
 * instruction set package
 * opcodes, alu ops, branch conditions, word layout and memory map
 */
`default_nettype none

package isaPkg;

	localparam int wordWidth   = 16;
	localparam int regCount    = 16;
	localparam int memDepth    = 1024;
	localparam int memAddrWidth = $clog2(memDepth);
	localparam int ioWidth     = 10;                        // switches and leds
	localparam logic [wordWidth-1:0] switchAddr = 16'h03FF; // read only
	localparam logic [wordWidth-1:0] ledAddr    = 16'h03FE; // write only

	// ext field codes for regOp, same as the immediate opcodes
	localparam logic [3:0] extAnd = 4'h1;
	localparam logic [3:0] extOr  = 4'h2;
	localparam logic [3:0] extXor = 4'h3;
	localparam logic [3:0] extAdd = 4'h5;
	localparam logic [3:0] extSub = 4'h9;
	localparam logic [3:0] extCmp = 4'hB;
	localparam logic [3:0] extMov = 4'hD;
	localparam logic [3:0] extLoad = 4'h0;    // memOp
	localparam logic [3:0] extStor = 4'h4;    // memOp
	localparam logic [3:0] extShiftRight = 4'h1; // shift, otherwise left

	typedef enum logic [3:0] {
		regOp = 4'h0, andi = 4'h1, ori = 4'h2, xori = 4'h3,
		memOp = 4'h4, addi = 4'h5, jcond = 4'h6, jal = 4'h7,
		shift = 4'h8, subi = 4'h9, cmpi = 4'hB, bcond = 4'hC,
		movi = 4'hD, lui = 4'hF
	} opcodeT;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluMov, aluLsh, aluRsh, aluPass2
	} aluOpT;

	typedef enum logic [3:0] {
		eq = 4'h0, ne = 4'h1, cs = 4'h2, cc = 4'h3,
		hi = 4'h4, ls = 4'h5, gt = 4'h6, le = 4'h7, uc = 4'hE
	} condT;

	typedef struct packed {
		logic carry;    // group one, add and sub only
		logic overflow;
		logic zero;     // group two, in1 against in2
		logic lower;
		logic negative;
	} flagsT;

	// imm8 is {ext, src}
	typedef struct packed {
		opcodeT     opcode;
		logic [3:0] dst;
		logic [3:0] ext;
		logic [3:0] src;
	} instrT;

endpackage

`default_nettype wire
